// File: Makefile
VERILATOR ?= verilator
TOP       ?= brRsTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)

.PHONY: all run check clean

all: check

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -qx "Test passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/brRsClkGen.sv
`timescale 1ns/1ps
`default_nettype none

module brRsClkGen #(
    parameter int HalfPeriod  = 2,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;  // released away from the sampling edge
    end

endmodule

`default_nettype wire

// File: bench/brRsTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "brRs_consts.svh"

module brRsTb;

    localparam int ClkPeriod      = 4;
    localparam int Depth          = 1 << `RS_DEPTH_LOG2;
    localparam int ResetCycles    = 4;
    localparam int DirectedCycles = 160;
    localparam int RandomCycles   = 600;
    localparam int DrainCycles    = 40;
    localparam int PlannedCycles  = ResetCycles + DirectedCycles + RandomCycles + DrainCycles;

    typedef struct packed {
        brInstPkg::word_t    instNum;
        brInstPkg::word_t    pc;
        brInstPkg::word_t    imm;
        wakeupPkg::physTag_t rd;
        wakeupPkg::physTag_t src1;
        wakeupPkg::physTag_t src2;
        logic                isBranch;
        logic                isJump;
        logic                taken;
        logic                hit;
        brInstPkg::funct3_t  funct3;
    } payload_t;

    logic clk;
    logic rstN;
    logic dispatchValid;
    payload_t dIn;
    wakeupPkg::readyPair_t srcReady;
    logic aluDone;
    logic mulDone;
    logic loadDone;
    wakeupPkg::physTag_t aluTag;
    wakeupPkg::physTag_t mulTag;
    wakeupPkg::physTag_t loadTag;
    logic exceptionSig;
    logic mretSig;
    logic mispredict;
    logic flushIn;

    logic full;
    logic issueValid;
    logic issueBranch;
    logic issueJump;
    logic issueTaken;
    logic issueHit;
    wakeupPkg::physTag_t issueRd;
    wakeupPkg::physTag_t issueSrc1Tag;
    wakeupPkg::physTag_t issueSrc2Tag;
    brInstPkg::word_t issueInstNum;
    brInstPkg::word_t issuePc;
    brInstPkg::word_t issueImm;
    brInstPkg::funct3_t issueFunct3;
    payload_t issuedPay;

    // reference queue, ready bits kept alongside
    payload_t modelQ[$];
    wakeupPkg::readyPair_t modelRdy[$];
    logic expValid;
    logic expFull;
    payload_t expPay;
    int expIssued = 0;
    int issuedCount = 0;
    int errorCount = 0;
    int seed = 885;
    brInstPkg::word_t nextInstNum = 1;

    brRsClkGen #(.HalfPeriod(ClkPeriod / 2), .ResetCycles(ResetCycles)) clkGen_i (
        .clk(clk), .rstN(rstN)
    );

    brRsTop dut_i (
        .clk(clk), .rstN(rstN), .dispatchValid(dispatchValid),
        .instNum(dIn.instNum), .pc(dIn.pc), .immediate(dIn.imm), .rd(dIn.rd),
        .src1Tag(dIn.src1), .src2Tag(dIn.src2), .srcReady(srcReady),
        .isJump(dIn.isJump), .isBranch(dIn.isBranch), .predTaken(dIn.taken),
        .predHit(dIn.hit), .funct3(dIn.funct3),
        .aluDone(aluDone), .aluTag(aluTag), .mulDone(mulDone), .mulTag(mulTag),
        .loadDone(loadDone), .loadTag(loadTag),
        .exceptionSig(exceptionSig), .mretSig(mretSig), .mispredict(mispredict),
        .full(full), .issueValid(issueValid), .issueBranch(issueBranch),
        .issueJump(issueJump), .issueTaken(issueTaken), .issueHit(issueHit),
        .issueRd(issueRd), .issueSrc1Tag(issueSrc1Tag), .issueSrc2Tag(issueSrc2Tag),
        .issueInstNum(issueInstNum), .issuePc(issuePc), .issueImm(issueImm),
        .issueFunct3(issueFunct3)
    );

    assign flushIn = exceptionSig | mretSig | mispredict;
    assign issuedPay = {issueInstNum, issuePc, issueImm, issueRd, issueSrc1Tag,
                        issueSrc2Tag, issueBranch, issueJump, issueTaken, issueHit,
                        issueFunct3};

    function automatic void reportError(input string msg);
        errorCount++;
        $display("[ERROR] %0t ns %s", $time, msg);
    endfunction

    function automatic logic tagSeen(input wakeupPkg::physTag_t t);
        return (aluDone && t == aluTag) || (mulDone && t == mulTag) ||
               (loadDone && t == loadTag);
    endfunction

    function automatic wakeupPkg::readyPair_t wakeBits(input payload_t e);
        return {tagSeen(e.src2), tagSeen(e.src1)};
    endfunction

    function automatic wakeupPkg::physTag_t randTag(input int mask);
        return wakeupPkg::physTag_t'($random(seed) & mask);
    endfunction

    function automatic payload_t randomPayload(input wakeupPkg::physTag_t s1,
                                               input wakeupPkg::physTag_t s2);
        payload_t p;
        p.instNum  = nextInstNum;  // unique, shows order in error lines
        p.pc       = $random(seed);
        p.imm      = $random(seed);
        p.rd       = randTag(255);
        p.src1     = s1;
        p.src2     = s2;
        p.isBranch = ($random(seed) & 1) != 0;
        p.isJump   = !p.isBranch;
        p.taken    = ($random(seed) & 1) != 0;
        p.hit      = ($random(seed) & 1) != 0;
        p.funct3   = brInstPkg::funct3_t'($random(seed));
        nextInstNum++;
        return p;
    endfunction

    // cycle model: pop a ready front, flush, wakeup, then dispatch
    always @(posedge clk) begin
        logic popNow;
        if (!rstN) begin
            modelQ.delete();
            modelRdy.delete();
            expValid <= 1'b0;
            expPay   <= '0;
            expFull  <= 1'b0;
        end else begin
            popNow = modelQ.size() > 0 && modelRdy[0] == 2'b11 && !flushIn;
            expValid <= popNow;
            expPay   <= popNow ? modelQ[0] : '0;
            if (popNow) begin
                void'(modelQ.pop_front());
                void'(modelRdy.pop_front());
                expIssued++;
            end
            if (flushIn) begin
                modelQ.delete();
                modelRdy.delete();
            end else begin
                foreach (modelRdy[i]) modelRdy[i] = modelRdy[i] | wakeBits(modelQ[i]);
                if (dispatchValid) begin
                    modelQ.push_back(dIn);
                    modelRdy.push_back(srcReady | wakeBits(dIn));
                end
            end
            expFull <= modelQ.size() == Depth;
        end
    end

    always @(posedge clk) begin
        if (issueValid === 1'b1) issuedCount++;
    end

    validMatches: assert property (@(posedge clk) disable iff (!rstN)
        issueValid == expValid)
        else reportError($sformatf("issueValid is %b, model expects %b",
            $sampled(issueValid), $sampled(expValid)));

    payloadMatches: assert property (@(posedge clk) disable iff (!rstN)
        (issueValid && expValid) |-> issuedPay == expPay)
        else reportError($sformatf("issued payload %h, model front %h",
            $sampled(issuedPay), $sampled(expPay)));

    zeroWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        !issueValid |-> issuedPay == '0)
        else reportError($sformatf("issue outputs %h while issueValid low",
            $sampled(issuedPay)));

    fullMatches: assert property (@(posedge clk) disable iff (!rstN)
        full == expFull)
        else reportError($sformatf("full is %b, model expects %b",
            $sampled(full), $sampled(expFull)));

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic dispatchOne(input wakeupPkg::physTag_t s1, input wakeupPkg::physTag_t s2,
                               input wakeupPkg::readyPair_t rdy);
        dIn = randomPayload(s1, s2);
        srcReady = rdy;
        dispatchValid = 1'b1;
        @(negedge clk);
        dispatchValid = 1'b0;
    endtask

    task automatic clearBcast();
        aluDone = 1'b0;
        mulDone = 1'b0;
        loadDone = 1'b0;
    endtask

    // unit 0 alu, 1 mul, 2 load
    task automatic pulseBcast(input int unit, input wakeupPkg::physTag_t tag);
        aluDone = unit == 0;
        mulDone = unit == 1;
        loadDone = unit == 2;
        aluTag = tag;
        mulTag = tag;
        loadTag = tag;
        @(negedge clk);
        clearBcast();
    endtask

    // 0 exception, 1 mret, 2 mispredict
    task automatic setFlush(input int which, input logic on);
        exceptionSig = on && which == 0;
        mretSig = on && which == 1;
        mispredict = on && which == 2;
    endtask

    // until the model is empty and every expected pulse came out of the DUT
    task automatic waitDrained();
        while (modelQ.size() != 0 || issuedCount != expIssued) @(negedge clk);
    endtask

    task automatic randomCycle();
        int flushPick;
        flushPick = $random(seed) & 127;
        dispatchValid = !full && (($random(seed) & 1) != 0);
        dIn = randomPayload(randTag(15), randTag(15));
        srcReady = wakeupPkg::readyPair_t'($random(seed));
        aluDone = ($random(seed) & 3) == 0;
        mulDone = ($random(seed) & 3) == 0;
        loadDone = ($random(seed) & 3) == 0;
        aluTag = randTag(15);
        mulTag = randTag(15);
        loadTag = randTag(15);
        setFlush(flushPick, flushPick < 3);
        @(negedge clk);
    endtask

    initial begin
        dispatchValid = 1'b0;
        dIn = '0;
        srcReady = '0;
        aluTag = '0;
        mulTag = '0;
        loadTag = '0;
        clearBcast();
        setFlush(0, 1'b0);
        wait (rstN === 1'b1);
        @(negedge clk);

        // ready on arrival, alone and back to back
        dispatchOne(randTag(255), randTag(255), 2'b11);
        waitDrained();
        repeat (3) dispatchOne(randTag(255), randTag(255), 2'b11);
        waitDrained();

        // unready head holds ready entries behind it
        for (int u = 0; u < 3; u++) begin
            dispatchOne(wakeupPkg::physTag_t'(8'hE0 + u), randTag(255), 2'b10);
            repeat (4) dispatchOne(randTag(255), randTag(255), 2'b11);
            idle(3);
            pulseBcast(u, wakeupPkg::physTag_t'(8'hE0 + u));
            waitDrained();
        end

        // same-cycle bypass
        aluDone = 1'b1;
        aluTag = 8'h31;
        mulDone = 1'b1;
        mulTag = 8'h32;
        dispatchOne(8'h31, 8'h32, 2'b00);
        clearBcast();
        waitDrained();
        loadDone = 1'b1;
        loadTag = 8'h33;
        dispatchOne(8'h33, 8'h33, 2'b00);
        clearBcast();
        waitDrained();

        // each flush source, with a dispatch in the flush cycle
        for (int f = 0; f < 3; f++) begin
            repeat (5) dispatchOne(randTag(255), randTag(255), 2'b00);
            setFlush(f, 1'b1);
            dispatchOne(randTag(255), randTag(255), 2'b11);
            setFlush(f, 1'b0);
            dispatchOne(randTag(255), randTag(255), 2'b11);
            waitDrained();
        end

        // fill to depth, then release through the load bus
        repeat (Depth) dispatchOne(8'hF0, randTag(255), 2'b10);
        idle(2);
        pulseBcast(2, 8'hF0);
        waitDrained();

        for (int c = 0; c < RandomCycles; c++) randomCycle();
        dispatchValid = 1'b0;
        setFlush(0, 1'b0);
        clearBcast();
        for (int t = 0; t < 16; t++) pulseBcast(t % 3, wakeupPkg::physTag_t'(t));
        waitDrained();
        idle(2);

        $display("%0d entries issued, %0d errors", issuedCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(2 * PlannedCycles * ClkPeriod);
        $display("watchdog expired before all tests completed");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/brInstPkg.sv
`default_nettype none

`include "brRs_consts.svh"

package brInstPkg;

    // slot index into the circular queue
    typedef logic [`RS_DEPTH_LOG2-1:0] rsIdx_t;

    // occupancy needs one more bit to reach depth
    typedef logic [`RS_DEPTH_LOG2:0] rsCount_t;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [2:0] funct3_t;  // beq/bne/blt/bge/bltu/bgeu

endpackage

`default_nettype wire

// File: logic/brRsDispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "brRs_consts.svh"

module brRsDispatch (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire                      flush,
    input  wire                      dispatchValid,
    input  wire  brInstPkg::word_t   instNum,
    input  wire  brInstPkg::word_t   pc,
    input  wire  brInstPkg::word_t   immediate,
    input  wire  wakeupPkg::physTag_t rd,
    input  wire                      isJump,
    input  wire                      isBranch,
    input  wire                      predTaken,
    input  wire                      predHit,
    input  wire  brInstPkg::funct3_t funct3,
    input  wire  wakeupPkg::physTag_t src1Tag,
    input  wire  wakeupPkg::physTag_t src2Tag,
    input  wire  wakeupPkg::readyPair_t srcReady,
    input  wire                      aluDone,
    input  wire  wakeupPkg::physTag_t aluTag,
    input  wire                      mulDone,
    input  wire  wakeupPkg::physTag_t mulTag,
    input  wire                      loadDone,
    input  wire  wakeupPkg::physTag_t loadTag,
    input  wire                      pop,
    input  wire  brInstPkg::rsIdx_t  headIdx,
    output logic                     full,
    output logic                     wrEn,
    output brInstPkg::rsIdx_t        wrIdx,
    output wakeupPkg::readyPair_t    wrReady,
    output wakeupPkg::physTag_t      wrSrc1Tag,
    output wakeupPkg::physTag_t      wrSrc2Tag,
    output logic                     headBranch,
    output logic                     headJump,
    output logic                     headTaken,
    output logic                     headHit,
    output wakeupPkg::physTag_t      headRd,
    output brInstPkg::word_t         headInstNum,
    output brInstPkg::word_t         headPc,
    output brInstPkg::word_t         headImm,
    output brInstPkg::funct3_t       headFunct3
);

    localparam int Depth = 1 << `RS_DEPTH_LOG2;

    brInstPkg::rsIdx_t   tail;
    brInstPkg::rsCount_t count;

    logic [Depth-1:0]    branchQ;
    logic [Depth-1:0]    jumpQ;
    logic [Depth-1:0]    takenQ;
    logic [Depth-1:0]    hitQ;
    wakeupPkg::physTag_t rdQ [Depth];
    brInstPkg::word_t    instNumQ [Depth];
    brInstPkg::word_t    pcQ [Depth];
    brInstPkg::word_t    immQ [Depth];
    brInstPkg::funct3_t  funct3Q [Depth];

    assign full  = (count == brInstPkg::rsCount_t'(Depth));
    assign wrEn  = dispatchValid && !flush;
    assign wrIdx = tail;

    // same-cycle bypass from the broadcast buses
    assign wrReady[0] = srcReady[0] ||
        wakeupPkg::bcastHit(src1Tag, aluDone, aluTag, mulDone, mulTag, loadDone, loadTag);
    assign wrReady[1] = srcReady[1] ||
        wakeupPkg::bcastHit(src2Tag, aluDone, aluTag, mulDone, mulTag, loadDone, loadTag);

    assign wrSrc1Tag = src1Tag;
    assign wrSrc2Tag = src2Tag;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (wrEn) tail <= tail + brInstPkg::rsIdx_t'(1);
            count <= count + brInstPkg::rsCount_t'(wrEn) - brInstPkg::rsCount_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            branchQ[tail]  <= isBranch;
            jumpQ[tail]    <= isJump;
            takenQ[tail]   <= predTaken;
            hitQ[tail]     <= predHit;
            rdQ[tail]      <= rd;
            instNumQ[tail] <= instNum;
            pcQ[tail]      <= pc;
            immQ[tail]     <= immediate;
            funct3Q[tail]  <= funct3;
        end
    end

    assign headBranch  = branchQ[headIdx];
    assign headJump    = jumpQ[headIdx];
    assign headTaken   = takenQ[headIdx];
    assign headHit     = hitQ[headIdx];
    assign headRd      = rdQ[headIdx];
    assign headInstNum = instNumQ[headIdx];
    assign headPc      = pcQ[headIdx];
    assign headImm     = immQ[headIdx];
    assign headFunct3  = funct3Q[headIdx];

    // rename must stall on full
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        full |-> !dispatchValid)
        else $error("dispatch into a full branch queue");

    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        count <= brInstPkg::rsCount_t'(Depth))
        else $error("branch queue occupancy above depth");

endmodule

`default_nettype wire

// File: logic/brRsIssue.sv
`timescale 1ns/1ps
`default_nettype none

module brRsIssue (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       flush,
    input  wire                       headReady,
    input  wire                       headBranch,
    input  wire                       headJump,
    input  wire                       headTaken,
    input  wire                       headHit,
    input  wire  wakeupPkg::physTag_t headRd,
    input  wire  brInstPkg::word_t    headInstNum,
    input  wire  brInstPkg::word_t    headPc,
    input  wire  brInstPkg::word_t    headImm,
    input  wire  brInstPkg::funct3_t  headFunct3,
    input  wire  wakeupPkg::physTag_t headSrc1Tag,
    input  wire  wakeupPkg::physTag_t headSrc2Tag,
    output logic                      pop,
    output brInstPkg::rsIdx_t         headIdx,
    output logic                      issueValid,
    output logic                      issueBranch,
    output logic                      issueJump,
    output logic                      issueTaken,
    output logic                      issueHit,
    output wakeupPkg::physTag_t       issueRd,
    output wakeupPkg::physTag_t       issueSrc1Tag,
    output wakeupPkg::physTag_t       issueSrc2Tag,
    output brInstPkg::word_t          issueInstNum,
    output brInstPkg::word_t          issuePc,
    output brInstPkg::word_t          issueImm,
    output brInstPkg::funct3_t        issueFunct3
);

    // one entry per cycle, branch unit never stalls
    assign pop = headReady && !flush;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            headIdx <= '0;
        end else if (pop) begin
            headIdx <= headIdx + brInstPkg::rsIdx_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= pop;
        end
    end

    // outputs stay zero between issues
    always_ff @(posedge clk) begin
        if (!rstN || !pop) begin
            issueBranch  <= 1'b0;
            issueJump    <= 1'b0;
            issueTaken   <= 1'b0;
            issueHit     <= 1'b0;
            issueRd      <= '0;
            issueSrc1Tag <= '0;
            issueSrc2Tag <= '0;
            issueInstNum <= '0;
            issuePc      <= '0;
            issueImm     <= '0;
            issueFunct3  <= '0;
        end else begin
            issueBranch  <= headBranch;
            issueJump    <= headJump;
            issueTaken   <= headTaken;
            issueHit     <= headHit;
            issueRd      <= headRd;
            issueSrc1Tag <= headSrc1Tag;
            issueSrc2Tag <= headSrc2Tag;
            issueInstNum <= headInstNum;
            issuePc      <= headPc;
            issueImm     <= headImm;
            issueFunct3  <= headFunct3;
        end
    end

endmodule

`default_nettype wire

// File: logic/brRsTop.sv
`timescale 1ns/1ps
`default_nettype none

module brRsTop (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         dispatchValid,
    input  wire  brInstPkg::word_t      instNum,
    input  wire  brInstPkg::word_t      pc,
    input  wire  brInstPkg::word_t      immediate,
    input  wire  wakeupPkg::physTag_t   rd,
    input  wire  wakeupPkg::physTag_t   src1Tag,
    input  wire  wakeupPkg::physTag_t   src2Tag,
    input  wire  wakeupPkg::readyPair_t srcReady,
    input  wire                         isJump,
    input  wire                         isBranch,
    input  wire                         predTaken,
    input  wire                         predHit,
    input  wire  brInstPkg::funct3_t    funct3,
    input  wire                         aluDone,
    input  wire  wakeupPkg::physTag_t   aluTag,
    input  wire                         mulDone,
    input  wire  wakeupPkg::physTag_t   mulTag,
    input  wire                         loadDone,
    input  wire  wakeupPkg::physTag_t   loadTag,
    input  wire                         exceptionSig,
    input  wire                         mretSig,
    input  wire                         mispredict,
    output logic                        full,
    output logic                        issueValid,
    output logic                        issueBranch,
    output logic                        issueJump,
    output logic                        issueTaken,
    output logic                        issueHit,
    output wakeupPkg::physTag_t         issueRd,
    output wakeupPkg::physTag_t         issueSrc1Tag,
    output wakeupPkg::physTag_t         issueSrc2Tag,
    output brInstPkg::word_t            issueInstNum,
    output brInstPkg::word_t            issuePc,
    output brInstPkg::word_t            issueImm,
    output brInstPkg::funct3_t          issueFunct3
);

    logic                  flush;
    logic                  wrEn;
    brInstPkg::rsIdx_t     wrIdx;
    wakeupPkg::readyPair_t wrReady;
    wakeupPkg::physTag_t   wrSrc1Tag;
    wakeupPkg::physTag_t   wrSrc2Tag;
    logic                  pop;
    brInstPkg::rsIdx_t     headIdx;
    logic                  headReady;
    logic                  headBranch;
    logic                  headJump;
    logic                  headTaken;
    logic                  headHit;
    wakeupPkg::physTag_t   headRd;
    brInstPkg::word_t      headInstNum;
    brInstPkg::word_t      headPc;
    brInstPkg::word_t      headImm;
    brInstPkg::funct3_t    headFunct3;
    wakeupPkg::physTag_t   headSrc1Tag;
    wakeupPkg::physTag_t   headSrc2Tag;

    // any redirect drops every queued branch
    assign flush = exceptionSig | mretSig | mispredict;

    brRsDispatch dispatchInst (
        .clk(clk), .rstN(rstN), .flush(flush), .dispatchValid(dispatchValid),
        .instNum(instNum), .pc(pc), .immediate(immediate), .rd(rd),
        .isJump(isJump), .isBranch(isBranch), .predTaken(predTaken), .predHit(predHit),
        .funct3(funct3), .src1Tag(src1Tag), .src2Tag(src2Tag), .srcReady(srcReady),
        .aluDone(aluDone), .aluTag(aluTag), .mulDone(mulDone), .mulTag(mulTag),
        .loadDone(loadDone), .loadTag(loadTag), .pop(pop), .headIdx(headIdx),
        .full(full), .wrEn(wrEn), .wrIdx(wrIdx), .wrReady(wrReady),
        .wrSrc1Tag(wrSrc1Tag), .wrSrc2Tag(wrSrc2Tag),
        .headBranch(headBranch), .headJump(headJump), .headTaken(headTaken),
        .headHit(headHit), .headRd(headRd), .headInstNum(headInstNum),
        .headPc(headPc), .headImm(headImm), .headFunct3(headFunct3)
    );

    brRsWakeup wakeupInst (
        .clk(clk), .rstN(rstN), .flush(flush),
        .wrEn(wrEn), .wrIdx(wrIdx), .wrReady(wrReady),
        .wrSrc1Tag(wrSrc1Tag), .wrSrc2Tag(wrSrc2Tag),
        .aluDone(aluDone), .aluTag(aluTag), .mulDone(mulDone), .mulTag(mulTag),
        .loadDone(loadDone), .loadTag(loadTag), .pop(pop), .headIdx(headIdx),
        .headReady(headReady), .headSrc1Tag(headSrc1Tag), .headSrc2Tag(headSrc2Tag)
    );

    brRsIssue issueInst (
        .clk(clk), .rstN(rstN), .flush(flush), .headReady(headReady),
        .headBranch(headBranch), .headJump(headJump), .headTaken(headTaken),
        .headHit(headHit), .headRd(headRd), .headInstNum(headInstNum),
        .headPc(headPc), .headImm(headImm), .headFunct3(headFunct3),
        .headSrc1Tag(headSrc1Tag), .headSrc2Tag(headSrc2Tag),
        .pop(pop), .headIdx(headIdx), .issueValid(issueValid),
        .issueBranch(issueBranch), .issueJump(issueJump), .issueTaken(issueTaken),
        .issueHit(issueHit), .issueRd(issueRd), .issueSrc1Tag(issueSrc1Tag),
        .issueSrc2Tag(issueSrc2Tag), .issueInstNum(issueInstNum),
        .issuePc(issuePc), .issueImm(issueImm), .issueFunct3(issueFunct3)
    );

endmodule

`default_nettype wire

// File: logic/brRsWakeup.sv
`timescale 1ns/1ps
`default_nettype none

`include "brRs_consts.svh"

module brRsWakeup (
    input  wire                        clk,
    input  wire                        rstN,
    input  wire                        flush,
    input  wire                        wrEn,
    input  wire  brInstPkg::rsIdx_t    wrIdx,
    input  wire  wakeupPkg::readyPair_t wrReady,
    input  wire  wakeupPkg::physTag_t  wrSrc1Tag,
    input  wire  wakeupPkg::physTag_t  wrSrc2Tag,
    input  wire                        aluDone,
    input  wire  wakeupPkg::physTag_t  aluTag,
    input  wire                        mulDone,
    input  wire  wakeupPkg::physTag_t  mulTag,
    input  wire                        loadDone,
    input  wire  wakeupPkg::physTag_t  loadTag,
    input  wire                        pop,
    input  wire  brInstPkg::rsIdx_t    headIdx,
    output logic                       headReady,
    output wakeupPkg::physTag_t        headSrc1Tag,
    output wakeupPkg::physTag_t        headSrc2Tag
);

    localparam int Depth = 1 << `RS_DEPTH_LOG2;

    logic [Depth-1:0]      occ;           // slot holds a live entry
    wakeupPkg::readyPair_t rdy [Depth];
    wakeupPkg::physTag_t   src1Tags [Depth];
    wakeupPkg::physTag_t   src2Tags [Depth];

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            occ <= '0;
            for (int i = 0; i < Depth; i++) begin
                rdy[i] <= '0;
            end
        end else begin
            // broadcast wakeup of waiting slots
            for (int i = 0; i < Depth; i++) begin
                if (occ[i] && wakeupPkg::bcastHit(src1Tags[i], aluDone, aluTag,
                        mulDone, mulTag, loadDone, loadTag)) begin
                    rdy[i][0] <= 1'b1;
                end
                if (occ[i] && wakeupPkg::bcastHit(src2Tags[i], aluDone, aluTag,
                        mulDone, mulTag, loadDone, loadTag)) begin
                    rdy[i][1] <= 1'b1;
                end
            end
            if (pop) begin
                occ[headIdx] <= 1'b0;
                rdy[headIdx] <= '0;
            end
            if (wrEn) begin
                occ[wrIdx] <= 1'b1;
                rdy[wrIdx] <= wrReady;  // bypass already folded in
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            src1Tags[wrIdx] <= wrSrc1Tag;
            src2Tags[wrIdx] <= wrSrc2Tag;
        end
    end

    assign headReady   = occ[headIdx] && (rdy[headIdx] == 2'b11);
    assign headSrc1Tag = src1Tags[headIdx];
    assign headSrc2Tag = src2Tags[headIdx];

    // tail never overruns a live slot
    writeToFreeSlot: assert property (@(posedge clk) disable iff (!rstN)
        wrEn |-> !occ[wrIdx])
        else $error("dispatch overwrote an occupied slot");

endmodule

`default_nettype wire

// File: logic/brRs_consts.svh
`ifndef BRRS_CONSTS_SVH
`define BRRS_CONSTS_SVH

// 16 slot queue
`define RS_DEPTH_LOG2 4

// physical register file has 256 entries
`define PHYS_TAG_W 8

// pc, immediate and instruction number
`define XLEN 32

`endif

// File: logic/wakeupPkg.sv
`default_nettype none

`include "brRs_consts.svh"

package wakeupPkg;

    typedef logic [`PHYS_TAG_W-1:0] physTag_t;

    typedef logic [1:0] readyPair_t;  // bit 0 src1, bit 1 src2

    // tag matches any live result broadcast
    function automatic logic bcastHit(
        input physTag_t tag,
        input logic     aluDone,
        input physTag_t aluTag,
        input logic     mulDone,
        input physTag_t mulTag,
        input logic     loadDone,
        input physTag_t loadTag
    );
        return (aluDone && tag == aluTag) || (mulDone && tag == mulTag) ||
               (loadDone && tag == loadTag);
    endfunction

endpackage

`default_nettype wire

// File: sim.f
+incdir+logic
logic/brInstPkg.sv
logic/wakeupPkg.sv
logic/brRsDispatch.sv
logic/brRsWakeup.sv
logic/brRsIssue.sv
logic/brRsTop.sv
bench/brRsClkGen.sv
bench/brRsTb.sv
